// File: qerv_config.svh
`ifndef QERV_CONFIG_SVH
`define QERV_CONFIG_SVH

// Data word width
`define QERV_XLEN 32

// Bits moved through the datapath per cycle
`define QERV_W 4

// Architectural registers, x0 included
`define QERV_NREG 32

// Address of the first instruction fetch
`define QERV_RESET_PC 32'h0000_0000

`endif

// File: qerv_pkg.sv
`include "qerv_config.svh"

package qerv_pkg;

   typedef logic [`QERV_XLEN-1:0] word_t;
   typedef logic [`QERV_W-1:0] nibble_t;
   typedef logic [$clog2(`QERV_NREG)-1:0] reg_addr_t;
   // Nibble position within a word, LSB nibble first
   typedef logic [$clog2(`QERV_XLEN/`QERV_W)-1:0] cnt_t;

   typedef enum logic [1:0] {
      st_fetch = 2'd0,
      st_exec  = 2'd1,
      st_mem   = 2'd2,
      st_wb    = 2'd3
   } state_t;

   typedef enum logic [2:0] {
      op_none  = 3'd0,
      op_reg   = 3'd1,
      op_imm   = 3'd2,
      op_load  = 3'd3,
      op_store = 3'd4
   } op_class_t;

   typedef enum logic [2:0] {
      alu_add = 3'd0,
      alu_sub = 3'd1,
      alu_and = 3'd2,
      alu_or  = 3'd3,
      alu_xor = 3'd4
   } alu_op_t;

endpackage

// File: qerv_decode.sv
`timescale 1ns/10ps
`include "qerv_config.svh"

module qerv_decode (
   input  logic                clk,
   input  qerv_pkg::word_t     i_instr,
   input  logic                i_load,
   input  logic                i_cnt_en,
   output qerv_pkg::op_class_t o_op_class,
   output qerv_pkg::alu_op_t   o_alu_op,
   output logic                o_op_b_imm,
   output logic                o_we,
   output qerv_pkg::reg_addr_t o_rd_addr,
   output qerv_pkg::reg_addr_t o_rs1_addr,
   output qerv_pkg::reg_addr_t o_rs2_addr,
   output qerv_pkg::nibble_t   o_imm
);

   qerv_pkg::word_t instr;
   qerv_pkg::word_t imm;
   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;

   always_ff @(posedge clk) begin
      if (i_load) begin
         instr <= i_instr;
         // S-type splits the immediate around rd
         if (i_instr[6:0] == 7'b0100011)
            imm <= {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
         else
            imm <= {{20{i_instr[31]}}, i_instr[31:20]};
      end else if (i_cnt_en) begin
         imm <= imm >> `QERV_W;
      end
   end

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   always_comb begin
      o_op_class = qerv_pkg::op_none;
      o_alu_op   = qerv_pkg::alu_add;
      case (opcode)
         7'b0110011: begin
            o_op_class = qerv_pkg::op_reg;
            case (funct3)
               3'b000: o_alu_op = funct7[5] ? qerv_pkg::alu_sub : qerv_pkg::alu_add;
               3'b100: o_alu_op = qerv_pkg::alu_xor;
               3'b110: o_alu_op = qerv_pkg::alu_or;
               3'b111: o_alu_op = qerv_pkg::alu_and;
               default: o_op_class = qerv_pkg::op_none;
            endcase
            // Only SUB may set funct7, and only bit 5
            if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b000))
               o_op_class = qerv_pkg::op_none;
         end
         7'b0010011: begin
            o_op_class = qerv_pkg::op_imm;
            case (funct3)
               3'b000: o_alu_op = qerv_pkg::alu_add;
               3'b100: o_alu_op = qerv_pkg::alu_xor;
               3'b110: o_alu_op = qerv_pkg::alu_or;
               3'b111: o_alu_op = qerv_pkg::alu_and;
               default: o_op_class = qerv_pkg::op_none;
            endcase
         end
         7'b0000011: if (funct3 == 3'b010) o_op_class = qerv_pkg::op_load;
         7'b0100011: if (funct3 == 3'b010) o_op_class = qerv_pkg::op_store;
         default: o_op_class = qerv_pkg::op_none;
      endcase
   end

   assign o_op_b_imm = (o_op_class == qerv_pkg::op_imm);
   assign o_we       = (o_op_class == qerv_pkg::op_store);
   assign o_rd_addr  = instr[11:7];
   assign o_rs1_addr = instr[19:15];
   assign o_rs2_addr = instr[24:20];
   assign o_imm      = imm[`QERV_W-1:0];

endmodule

// File: qerv_state.sv
`timescale 1ns/10ps

module qerv_state (
   input  logic                clk,
   input  logic                i_rst,
   input  qerv_pkg::op_class_t i_op_class,
   input  logic                i_ibus_ack,
   input  logic                i_dbus_ack,
   output logic                o_ibus_cyc,
   output logic                o_dbus_cyc,
   output logic                o_cnt_en,
   output qerv_pkg::cnt_t      o_cnt,
   output logic                o_rd_wen,
   output logic                o_wb_sel
);

   qerv_pkg::state_t state;
   qerv_pkg::cnt_t   cnt;
   logic             ibus_cyc;
   logic             dbus_cyc;
   logic             cnt_last;
   logic             mem_op;
   logic             alu_wr;

   assign cnt_last = &cnt;
   assign mem_op   = (i_op_class == qerv_pkg::op_load) || (i_op_class == qerv_pkg::op_store);
   assign alu_wr   = (i_op_class == qerv_pkg::op_reg) || (i_op_class == qerv_pkg::op_imm);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state    <= qerv_pkg::st_fetch;
         cnt      <= '0;
         ibus_cyc <= 1'b0;
         dbus_cyc <= 1'b0;
      end else begin
         // Counter wraps to zero at the end of each serial phase
         if (state == qerv_pkg::st_exec || state == qerv_pkg::st_wb)
            cnt <= cnt + qerv_pkg::cnt_t'(1);
         case (state)
            qerv_pkg::st_fetch: begin
               ibus_cyc <= !i_ibus_ack;
               if (i_ibus_ack)
                  state <= qerv_pkg::st_exec;
            end
            qerv_pkg::st_exec: begin
               if (cnt_last) begin
                  if (mem_op) begin
                     state    <= qerv_pkg::st_mem;
                     dbus_cyc <= 1'b1;
                  end else begin
                     state    <= qerv_pkg::st_fetch;
                     ibus_cyc <= 1'b1;
                  end
               end
            end
            qerv_pkg::st_mem: begin
               if (i_dbus_ack) begin
                  dbus_cyc <= 1'b0;
                  if (i_op_class == qerv_pkg::op_load) begin
                     state <= qerv_pkg::st_wb;
                  end else begin
                     state    <= qerv_pkg::st_fetch;
                     ibus_cyc <= 1'b1;
                  end
               end
            end
            qerv_pkg::st_wb: begin
               if (cnt_last) begin
                  state    <= qerv_pkg::st_fetch;
                  ibus_cyc <= 1'b1;
               end
            end
            default: state <= qerv_pkg::st_fetch;
         endcase
      end
   end

   assign o_ibus_cyc = ibus_cyc;
   assign o_dbus_cyc = dbus_cyc;
   assign o_cnt      = cnt;
   // PC, ALU carry and address only advance in execute
   assign o_cnt_en   = (state == qerv_pkg::st_exec);
   assign o_wb_sel   = (state == qerv_pkg::st_wb);
   assign o_rd_wen   = (o_cnt_en && alu_wr) || o_wb_sel;

endmodule

// File: qerv_ctrl.sv
`timescale 1ns/10ps
`include "qerv_config.svh"

module qerv_ctrl (
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_cnt_en,
   input  qerv_pkg::cnt_t  i_cnt,
   output qerv_pkg::word_t o_pc
);

   qerv_pkg::word_t   pc;
   qerv_pkg::nibble_t addend;
   logic              first;
   logic              carry;
   logic              cin;
   logic [`QERV_W:0]  sum;

   assign first  = (i_cnt == '0);
   // Four lands in the lowest nibble only
   assign addend = first ? qerv_pkg::nibble_t'(4) : '0;
   assign cin    = first ? 1'b0 : carry;
   assign sum    = {1'b0, pc[`QERV_W-1:0]} + {1'b0, addend} + cin;

   always_ff @(posedge clk) begin
      if (i_rst)
         pc <= `QERV_RESET_PC;
      else if (i_cnt_en)
         pc <= {sum[`QERV_W-1:0], pc[`QERV_XLEN-1:`QERV_W]};
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en)
         carry <= sum[`QERV_W];
   end

   assign o_pc = pc;

endmodule

// File: qerv_rf.sv
`timescale 1ns/10ps
`include "qerv_config.svh"

module qerv_rf (
   input  logic                clk,
   input  qerv_pkg::cnt_t      i_cnt,
   input  qerv_pkg::reg_addr_t i_rs1_addr,
   input  qerv_pkg::reg_addr_t i_rs2_addr,
   input  qerv_pkg::reg_addr_t i_rd_addr,
   input  logic                i_wen,
   input  logic                i_wb_sel,
   input  qerv_pkg::nibble_t   i_wdata,
   input  qerv_pkg::nibble_t   i_ldata,
   output qerv_pkg::nibble_t   o_rs1,
   output qerv_pkg::nibble_t   o_rs2
);

   localparam int DEPTH = `QERV_NREG * (`QERV_XLEN / `QERV_W);

   // One entry per nibble, indexed by {register, nibble position}
   qerv_pkg::nibble_t mem [DEPTH];
   qerv_pkg::nibble_t wnib;

   // Load data during writeback, ALU result otherwise
   assign wnib = i_wb_sel ? i_ldata : i_wdata;

   always_ff @(posedge clk) begin
      if (i_wen && (i_rd_addr != '0))
         mem[{i_rd_addr, i_cnt}] <= wnib;
   end

   assign o_rs1 = (i_rs1_addr == '0) ? '0 : mem[{i_rs1_addr, i_cnt}];
   assign o_rs2 = (i_rs2_addr == '0) ? '0 : mem[{i_rs2_addr, i_cnt}];

endmodule

// File: qerv_alu.sv
`timescale 1ns/10ps
`include "qerv_config.svh"

module qerv_alu (
   input  logic              clk,
   input  logic              i_cnt_en,
   input  qerv_pkg::cnt_t    i_cnt,
   input  qerv_pkg::alu_op_t i_alu_op,
   input  logic              i_op_b_imm,
   input  qerv_pkg::nibble_t i_rs1,
   input  qerv_pkg::nibble_t i_rs2,
   input  qerv_pkg::nibble_t i_imm,
   output qerv_pkg::nibble_t o_rd
);

   qerv_pkg::nibble_t op_b;
   qerv_pkg::nibble_t b_in;
   logic              sub;
   logic              carry;
   logic              cin;
   logic [`QERV_W:0]  sum;

   assign op_b = i_op_b_imm ? i_imm : i_rs2;
   assign sub  = (i_alu_op == qerv_pkg::alu_sub);
   // Subtract as rs1 + ~b + 1, the +1 entering at the first nibble
   assign b_in = sub ? ~op_b : op_b;
   assign cin  = (i_cnt == '0) ? sub : carry;
   assign sum  = {1'b0, i_rs1} + {1'b0, b_in} + cin;

   always_ff @(posedge clk) begin
      if (i_cnt_en)
         carry <= sum[`QERV_W];
   end

   always_comb begin
      case (i_alu_op)
         qerv_pkg::alu_and: o_rd = i_rs1 & op_b;
         qerv_pkg::alu_or:  o_rd = i_rs1 | op_b;
         qerv_pkg::alu_xor: o_rd = i_rs1 ^ op_b;
         default:           o_rd = sum[`QERV_W-1:0];
      endcase
   end

endmodule

// File: qerv_bufreg.sv
`timescale 1ns/10ps
`include "qerv_config.svh"

module qerv_bufreg (
   input  logic              clk,
   input  logic              i_cnt_en,
   input  qerv_pkg::cnt_t    i_cnt,
   input  qerv_pkg::nibble_t i_rs1,
   input  qerv_pkg::nibble_t i_rs2,
   input  qerv_pkg::nibble_t i_imm,
   input  logic              i_ack,
   input  qerv_pkg::word_t   i_rdt,
   output qerv_pkg::word_t   o_adr,
   output qerv_pkg::word_t   o_dat,
   output qerv_pkg::nibble_t o_rd
);

   qerv_pkg::word_t  adr;
   qerv_pkg::word_t  dat;
   qerv_pkg::word_t  ldat;
   logic             carry;
   logic             cin;
   logic [`QERV_W:0] sum;

   assign cin = (i_cnt == '0) ? 1'b0 : carry;
   assign sum = {1'b0, i_rs1} + {1'b0, i_imm} + cin;

   // Address and store data fill from the top, LSB nibble first
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         adr   <= {sum[`QERV_W-1:0], adr[`QERV_XLEN-1:`QERV_W]};
         dat   <= {i_rs2, dat[`QERV_XLEN-1:`QERV_W]};
         carry <= sum[`QERV_W];
      end
   end

   // Writeback follows the ack directly, so the load buffer drains every cycle
   always_ff @(posedge clk) begin
      if (i_ack)
         ldat <= i_rdt;
      else
         ldat <= ldat >> `QERV_W;
   end

   // Word access only
   assign o_adr = {adr[`QERV_XLEN-1:2], 2'b00};
   assign o_dat = dat;
   assign o_rd  = ldat[`QERV_W-1:0];

endmodule

// File: qerv_arbiter.sv
`timescale 1ns/10ps

module qerv_arbiter (
   input  logic            clk,
   input  logic            i_rst,
   input  qerv_pkg::word_t i_ibus_adr,
   input  logic            i_ibus_cyc,
   output logic            o_ibus_ack,
   input  qerv_pkg::word_t i_dbus_adr,
   input  qerv_pkg::word_t i_dbus_dat,
   input  logic            i_dbus_we,
   input  logic            i_dbus_cyc,
   output logic            o_dbus_ack,
   output qerv_pkg::word_t o_mem_adr,
   output qerv_pkg::word_t o_mem_dat,
   output logic            o_mem_we,
   output logic            o_mem_cyc,
   input  qerv_pkg::word_t i_mem_rdt,
   input  logic            i_mem_ack
);

   logic busy;
   logic sel_d_r;
   logic sel_d;

   // While idle the data side wins, once granted the choice is held
   assign sel_d = busy ? sel_d_r : i_dbus_cyc;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         busy    <= 1'b0;
         sel_d_r <= 1'b0;
      end else if (busy) begin
         if (i_mem_ack)
            busy <= 1'b0;
      end else if ((i_ibus_cyc || i_dbus_cyc) && !i_mem_ack) begin
         busy    <= 1'b1;
         sel_d_r <= i_dbus_cyc;
      end
   end

   assign o_mem_cyc  = sel_d ? i_dbus_cyc : i_ibus_cyc;
   assign o_mem_adr  = sel_d ? i_dbus_adr : i_ibus_adr;
   assign o_mem_we   = sel_d && i_dbus_we;
   assign o_mem_dat  = i_dbus_dat;
   assign o_dbus_ack = i_mem_ack && sel_d;
   assign o_ibus_ack = i_mem_ack && !sel_d;

endmodule

// File: qerv_top.sv
`timescale 1ns/10ps

module qerv_top (
   input  logic            clk,
   input  logic            i_rst,
   output qerv_pkg::word_t o_mem_adr,
   output qerv_pkg::word_t o_mem_dat,
   output logic            o_mem_we,
   output logic            o_mem_cyc,
   input  qerv_pkg::word_t i_mem_rdt,
   input  logic            i_mem_ack
);

   qerv_pkg::op_class_t op_class;
   qerv_pkg::alu_op_t   alu_op;
   logic                op_b_imm;
   logic                dbus_we;
   qerv_pkg::reg_addr_t rd_addr;
   qerv_pkg::reg_addr_t rs1_addr;
   qerv_pkg::reg_addr_t rs2_addr;
   qerv_pkg::nibble_t   imm;

   logic                ibus_cyc;
   logic                ibus_ack;
   logic                dbus_cyc;
   logic                dbus_ack;
   logic                cnt_en;
   qerv_pkg::cnt_t      cnt;
   logic                rd_wen;
   logic                wb_sel;

   qerv_pkg::word_t     pc;
   qerv_pkg::word_t     dbus_adr;
   qerv_pkg::word_t     dbus_dat;
   qerv_pkg::nibble_t   rs1;
   qerv_pkg::nibble_t   rs2;
   qerv_pkg::nibble_t   alu_rd;
   qerv_pkg::nibble_t   mem_rd;

   qerv_state state (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_op_class (op_class),
      .i_ibus_ack (ibus_ack),
      .i_dbus_ack (dbus_ack),
      .o_ibus_cyc (ibus_cyc),
      .o_dbus_cyc (dbus_cyc),
      .o_cnt_en   (cnt_en),
      .o_cnt      (cnt),
      .o_rd_wen   (rd_wen),
      .o_wb_sel   (wb_sel)
   );

   // Instruction word is taken straight off the shared bus
   qerv_decode decode (
      .clk        (clk),
      .i_instr    (i_mem_rdt),
      .i_load     (ibus_ack),
      .i_cnt_en   (cnt_en),
      .o_op_class (op_class),
      .o_alu_op   (alu_op),
      .o_op_b_imm (op_b_imm),
      .o_we       (dbus_we),
      .o_rd_addr  (rd_addr),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_imm      (imm)
   );

   qerv_ctrl ctrl (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_cnt_en (cnt_en),
      .i_cnt    (cnt),
      .o_pc     (pc)
   );

   qerv_rf rf (
      .clk        (clk),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_wen      (rd_wen),
      .i_wb_sel   (wb_sel),
      .i_wdata    (alu_rd),
      .i_ldata    (mem_rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   qerv_alu alu (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .i_alu_op   (alu_op),
      .i_op_b_imm (op_b_imm),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_imm      (imm),
      .o_rd       (alu_rd)
   );

   qerv_bufreg bufreg (
      .clk      (clk),
      .i_cnt_en (cnt_en),
      .i_cnt    (cnt),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .i_imm    (imm),
      .i_ack    (dbus_ack),
      .i_rdt    (i_mem_rdt),
      .o_adr    (dbus_adr),
      .o_dat    (dbus_dat),
      .o_rd     (mem_rd)
   );

   qerv_arbiter arbiter (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_ibus_adr (pc),
      .i_ibus_cyc (ibus_cyc),
      .o_ibus_ack (ibus_ack),
      .i_dbus_adr (dbus_adr),
      .i_dbus_dat (dbus_dat),
      .i_dbus_we  (dbus_we),
      .i_dbus_cyc (dbus_cyc),
      .o_dbus_ack (dbus_ack),
      .o_mem_adr  (o_mem_adr),
      .o_mem_dat  (o_mem_dat),
      .o_mem_we   (o_mem_we),
      .o_mem_cyc  (o_mem_cyc),
      .i_mem_rdt  (i_mem_rdt),
      .i_mem_ack  (i_mem_ack)
   );

endmodule

// File: qerv_assertions.sv
`timescale 1ns/10ps

module qerv_assertions (
   input logic            clk,
   input logic            i_rst,
   input qerv_pkg::word_t i_adr,
   input qerv_pkg::word_t i_dat,
   input logic            i_we,
   input logic            i_cyc,
   input logic            i_ack
);

   int rst_fails  = 0;
   int hold_fails = 0;
   int ack_fails  = 0;

   // Synchronous reset clears the request one edge later
   cyc_low_in_reset: assert property (@(posedge clk) i_rst |=> !i_cyc)
      else begin
         $error("Bus request active during reset");
         rst_fails++;
      end

   // Request and its qualifiers held until acknowledged
   req_held_until_ack: assert property (@(posedge clk) disable iff (i_rst)
      i_cyc && !i_ack |=> i_cyc && $stable(i_adr) && $stable(i_dat) && $stable(i_we))
      else begin
         $error("Bus request changed before ack");
         hold_fails++;
      end

   ack_only_with_cyc: assert property (@(posedge clk) disable iff (i_rst) i_ack |-> i_cyc)
      else begin
         $error("Ack without a bus request");
         ack_fails++;
      end

endmodule

// File: tb_qerv.sv
`timescale 1ns/10ps
`include "qerv_config.svh"

module tb_qerv;

   localparam int N_TESTS   = 6;
   localparam int MAX_INSTR = 30;
   localparam int MEM_WORDS = 128;
   localparam int DATA_WORD = 64;
   localparam qerv_pkg::word_t DATA_BASE = 32'h0000_0100;
   localparam qerv_pkg::word_t NOP       = 32'h0000_0013;

   logic            clk     = 1'b0;
   logic            rst     = 1'b1;
   qerv_pkg::word_t mem_rdt = '0;
   logic            mem_ack = 1'b0;
   qerv_pkg::word_t mem_adr;
   qerv_pkg::word_t mem_dat;
   logic            mem_we;
   logic            mem_cyc;

   // Code in words 0 to 63, data in words 64 to 127
   qerv_pkg::word_t mem [MEM_WORDS];
   qerv_pkg::word_t regs [32];
   qerv_pkg::word_t exp_adr [$];
   qerv_pkg::word_t exp_dat [$];
   qerv_pkg::word_t got_adr [$];
   qerv_pkg::word_t got_dat [$];
   qerv_pkg::word_t exp_pc;
   integer          seed      = 32'hf0b0;
   int              n_instr   = 0;
   int              errs      = 0;
   int              n_pass    = 0;
   int              n_fail    = 0;
   int              wait_left = 0;
   logic            pending   = 1'b0;
   logic            prog_done = 1'b0;
   string           test_name = "";

   qerv_top dut (
      .clk       (clk),
      .i_rst     (rst),
      .o_mem_adr (mem_adr),
      .o_mem_dat (mem_dat),
      .o_mem_we  (mem_we),
      .o_mem_cyc (mem_cyc),
      .i_mem_rdt (mem_rdt),
      .i_mem_ack (mem_ack)
   );

   bind qerv_top qerv_assertions u_assertions (
      .clk   (clk),
      .i_rst (i_rst),
      .i_adr (o_mem_adr),
      .i_dat (o_mem_dat),
      .i_we  (o_mem_we),
      .i_cyc (o_mem_cyc),
      .i_ack (i_mem_ack)
   );

   always #5 clk = ~clk;

   task automatic check_word(input string name, input qerv_pkg::word_t exp,
                             input qerv_pkg::word_t act);
      if (act !== exp) begin
         $display("** Error %s: data expected %h, actual %h", name, exp, act);
         errs++;
      end
   endtask

   task automatic check_adr(input string name, input qerv_pkg::word_t exp,
                            input qerv_pkg::word_t act);
      if (act !== exp) begin
         $display("** Error %s: address expected %h, actual %h", name, exp, act);
         errs++;
      end
   endtask

   function automatic qerv_pkg::word_t sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   // ISA semantics of the supported ALU operations
   function automatic qerv_pkg::word_t alu_model(input qerv_pkg::alu_op_t op,
                                                input qerv_pkg::word_t a,
                                                input qerv_pkg::word_t b);
      case (op)
         qerv_pkg::alu_sub: return a - b;
         qerv_pkg::alu_and: return a & b;
         qerv_pkg::alu_or:  return a | b;
         qerv_pkg::alu_xor: return a ^ b;
         default:           return a + b;
      endcase
   endfunction

   function automatic logic [2:0] funct3_of(input qerv_pkg::alu_op_t op);
      case (op)
         qerv_pkg::alu_xor: return 3'b100;
         qerv_pkg::alu_or:  return 3'b110;
         qerv_pkg::alu_and: return 3'b111;
         default:           return 3'b000;
      endcase
   endfunction

   task automatic emit(input qerv_pkg::word_t instr);
      mem[n_instr] = instr;
      n_instr++;
   endtask

   task automatic emit_r(input qerv_pkg::alu_op_t op, input int rd, input int rs1,
                         input int rs2);
      logic [6:0] f7;
      f7 = (op == qerv_pkg::alu_sub) ? 7'b0100000 : 7'b0000000;
      emit({f7, 5'(rs2), 5'(rs1), funct3_of(op), 5'(rd), 7'b0110011});
      if (rd != 0)
         regs[rd] = alu_model(op, regs[rs1], regs[rs2]);
   endtask

   task automatic emit_i(input qerv_pkg::alu_op_t op, input int rd, input int rs1,
                         input logic [11:0] imm);
      emit({imm, 5'(rs1), funct3_of(op), 5'(rd), 7'b0010011});
      if (rd != 0)
         regs[rd] = alu_model(op, regs[rs1], sext12(imm));
   endtask

   task automatic emit_lw(input int rd, input int rs1, input logic [11:0] off);
      qerv_pkg::word_t adr;
      adr = regs[rs1] + sext12(off);
      emit({off, 5'(rs1), 3'b010, 5'(rd), 7'b0000011});
      if (rd != 0)
         regs[rd] = mem[adr[8:2]];
   endtask

   task automatic emit_sw(input int rs2, input int rs1, input logic [11:0] off);
      qerv_pkg::word_t adr;
      adr = regs[rs1] + sext12(off);
      emit({off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], 7'b0100011});
      exp_adr.push_back(adr);
      exp_dat.push_back(regs[rs2]);
   endtask

   // Kind 0 register ops, kind 1 immediate ops, kind 2 load then store
   task automatic build_program(input int kind);
      int          i;
      int          k;
      int          rd;
      int          rs1;
      int          rs2;
      logic [11:0] off;
      n_instr = 0;
      for (i = 0; i < 32; i++)
         regs[i] = '0;
      for (i = 0; i < MEM_WORDS; i++)
         mem[i] = (i < DATA_WORD) ? NOP : qerv_pkg::word_t'($random(seed));
      // x31 is the data pointer, loads below it and stores above it
      emit_i(qerv_pkg::alu_add, 31, 0, 12'h180);
      if (kind == 2) begin
         for (i = 0; i < 10; i++) begin
            rd  = 1 + ($unsigned($random(seed)) % 8);
            off = 12'hf80 + 12'(4 * ($random(seed) & 31));
            emit_lw(rd, 31, off);
            emit_sw(rd, 31, 12'(4 * i));
         end
      end else begin
         for (i = 1; i <= 8; i++) begin
            off = 12'hf80 + 12'(4 * ($random(seed) & 31));
            emit_lw(i, 31, off);
         end
         for (i = 0; i < 12; i++) begin
            rd  = $unsigned($random(seed)) % 9;
            rs1 = $unsigned($random(seed)) % 9;
            rs2 = $unsigned($random(seed)) % 9;
            if (kind == 0) begin
               k = $unsigned($random(seed)) % 5;
               emit_r(qerv_pkg::alu_op_t'(k), rd, rs1, rs2);
            end else begin
               k   = $unsigned($random(seed)) % 4;
               k   = (k == 1) ? 4 : k;
               off = 12'($random(seed));
               emit_i(qerv_pkg::alu_op_t'(k), rd, rs1, off);
            end
         end
         for (i = 0; i <= 8; i++)
            emit_sw(i, 31, 12'(4 * i));
      end
   endtask

   task automatic serve_access();
      if (mem_adr >= 4 * MEM_WORDS) begin
         $display("%s: bus access outside the memory at %h", test_name, mem_adr);
         errs++;
      end else if (mem_we) begin
         if (mem_adr < DATA_BASE) begin
            $display("%s: bus write outside the data region at %h", test_name, mem_adr);
            errs++;
         end else begin
            mem[mem_adr[8:2]] = mem_dat;
         end
         got_adr.push_back(mem_adr);
         got_dat.push_back(mem_dat);
      end else begin
         mem_rdt <= mem[mem_adr[8:2]];
         if (mem_adr < DATA_BASE) begin
            check_adr({test_name, "/fetch"}, exp_pc, mem_adr);
            exp_pc = exp_pc + 4;
            if (mem_adr == 4 * n_instr)
               prog_done = 1'b1;
         end
      end
   endtask

   // Bus slave, 0 to 3 wait cycles per access
   always @(posedge clk) begin
      mem_ack <= 1'b0;
      if (rst) begin
         pending = 1'b0;
      end else if (mem_cyc && !mem_ack) begin
         if (!pending) begin
            pending   = 1'b1;
            wait_left = $random(seed) & 3;
         end
         if (wait_left == 0) begin
            pending = 1'b0;
            mem_ack <= 1'b1;
            serve_access();
         end else begin
            wait_left--;
         end
      end
   end

   task automatic run_test(input int idx);
      int    i;
      string base;
      @(posedge clk);
      rst <= 1'b1;
      @(posedge clk);
      case (idx % 3)
         0:       base = "reg_ops";
         1:       base = "imm_ops";
         default: base = "load_store";
      endcase
      test_name = $sformatf("%s_%0d", base, idx);
      errs      = 0;
      exp_pc    = `QERV_RESET_PC;
      prog_done = 1'b0;
      exp_adr.delete();
      exp_dat.delete();
      got_adr.delete();
      got_dat.delete();
      build_program(idx % 3);
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      repeat (2) @(posedge clk);
      if (!mem_cyc) begin
         $display("%s: no fetch request in the first cycle after reset", test_name);
         errs++;
      end
      while (!prog_done)
         @(posedge clk);
      if (got_adr.size() != exp_adr.size()) begin
         $display("** Error %s: store count expected %0d, actual %0d", test_name,
                  exp_adr.size(), got_adr.size());
         errs++;
      end else begin
         for (i = 0; i < exp_adr.size(); i++) begin
            check_adr({test_name, "/store"}, exp_adr[i], got_adr[i]);
            check_word({test_name, "/store"}, exp_dat[i], got_dat[i]);
         end
      end
      if (errs == 0)
         n_pass++;
      else
         n_fail++;
      $display("%-14s %s  errors: %0d", test_name, (errs == 0) ? "ok" : "FAILED", errs);
   endtask

   initial begin
      int t;
      int bus_fails;
      for (t = 0; t < N_TESTS; t++)
         run_test(t);
      bus_fails = dut.u_assertions.rst_fails + dut.u_assertions.hold_fails
                  + dut.u_assertions.ack_fails;
      $display("Tests run: %0d, ok: %0d, failing: %0d, assertion failures: %0d",
               N_TESTS, n_pass, n_fail, bus_fails);
      if (n_fail == 0 && bus_fails == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // Generous bound of 40 cycles per instruction
   initial begin
      #(N_TESTS * MAX_INSTR * 40 * 10);
      $display("Watchdog expired before the tests finished");
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: src.f
+incdir+.
qerv_pkg.sv
qerv_decode.sv
qerv_state.sv
qerv_ctrl.sv
qerv_rf.sv
qerv_alu.sv
qerv_bufreg.sv
qerv_arbiter.sv
qerv_top.sv
qerv_assertions.sv
tb_qerv.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_qerv -f src.f

run: compile
	@out="$$(./obj_dir/Vtb_qerv +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
